// File: include/paillier_consts.svh
`ifndef PAILLIER_CONSTS_SVH
`define PAILLIER_CONSTS_SVH

// Bits per operand word
`define PAILLIER_WIDTH 32

// Operand pairs per task
`define PAILLIER_TASK_LEN 4

// FIFO address bits, log2 of the task length
`define PAILLIER_FIFO_AW 2

// n squared for n = 2773, every operand must stay below it
`define PAILLIER_MODULUS 32'h0075_5539

`endif

// File: verilog/paillier_pkg.sv
`default_nettype none

`include "paillier_consts.svh"

package paillier_pkg;

    typedef logic [`PAILLIER_WIDTH-1:0] word_t;

    // Addition carries c1 and c2, scalar multiplication the ciphertext and its constant
    typedef struct packed {
        word_t first;
        word_t second;
    } operand_pair_t;

    typedef enum logic [1:0] {
        CMD_HOMO_ADD   = 2'd2,
        CMD_SCALAR_MUL = 2'd3
    } task_cmd_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT,
        ST_END
    } seq_state_t;

    typedef logic [`PAILLIER_FIFO_AW:0] count_t;  // Holds the full task length

endpackage

`default_nettype wire

// File: verilog/mod_op_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mod_op_if;
    import paillier_pkg::*;

    logic  start;   // One-cycle request, a and b sampled on this edge
    word_t a;
    word_t b;
    word_t result;
    logic  done;    // One-cycle pulse, result valid with it

    modport requester (
        output start,
        output a,
        output b,
        input  result,
        input  done
    );

    modport engine (
        input  start,
        input  a,
        input  b,
        output result,
        output done
    );

endinterface

`default_nettype wire

// File: verilog/operand_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "paillier_consts.svh"

module operand_fifo (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        push,
    input  logic                        pop,
    input  paillier_pkg::operand_pair_t write_data,
    output paillier_pkg::operand_pair_t read_data,
    output logic                        empty,
    output logic                        full
);
    import paillier_pkg::*;

    localparam count_t DEPTH = count_t'(`PAILLIER_TASK_LEN);

    operand_pair_t                mem [`PAILLIER_TASK_LEN];
    logic [`PAILLIER_FIFO_AW-1:0] wr_ptr;
    logic [`PAILLIER_FIFO_AW-1:0] rd_ptr;
    count_t                       level;
    logic                         do_push;
    logic                         do_pop;

    assign empty     = (level == '0);
    assign full      = (level == DEPTH);
    assign do_push   = push && !full;
    assign do_pop    = pop && !empty;
    assign read_data = mem[rd_ptr];  // Head is visible the cycle after its push

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= write_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two so the pointer wraps
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/mod_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

`include "paillier_consts.svh"

module mod_multiplier (
    input  logic     clk,
    input  logic     rst_n,
    mod_op_if.engine op
);
    import paillier_pkg::*;

    localparam int CW = $clog2(`PAILLIER_WIDTH);
    localparam logic [`PAILLIER_WIDTH:0] MOD_EXT = {1'b0, `PAILLIER_MODULUS};

    logic [`PAILLIER_WIDTH:0] acc;      // One bit of headroom over a word
    logic [`PAILLIER_WIDTH:0] dbl;
    logic [`PAILLIER_WIDTH:0] dbl_red;
    logic [`PAILLIER_WIDTH:0] sum;
    logic [`PAILLIER_WIDTH:0] sum_red;
    word_t                    a_q;
    word_t                    b_q;
    logic [CW-1:0]            bit_cnt;
    logic                     busy;
    logic                     done_q;

    // Both partial values stay below 2n^2, so one subtraction each is enough
    always_comb begin
        dbl     = acc << 1;
        dbl_red = (dbl >= MOD_EXT) ? dbl - MOD_EXT : dbl;
        sum     = b_q[`PAILLIER_WIDTH-1] ? dbl_red + {1'b0, a_q} : dbl_red;
        sum_red = (sum >= MOD_EXT) ? sum - MOD_EXT : sum;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (op.start && !busy) begin
                busy    <= 1'b1;
                bit_cnt <= CW'(`PAILLIER_WIDTH - 1);
            end else if (busy) begin
                bit_cnt <= bit_cnt - 1'b1;
                if (bit_cnt == '0) begin
                    busy   <= 1'b0;
                    done_q <= 1'b1;   // Lands PAILLIER_WIDTH+1 cycles after start
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op.start && !busy) begin
            a_q <= op.a;
            b_q <= op.b;
            acc <= '0;
        end else if (busy) begin
            acc <= sum_red;
            b_q <= b_q << 1;          // Next multiplier bit moves to the top
        end
    end

    assign op.result = acc[`PAILLIER_WIDTH-1:0];
    assign op.done   = done_q;

endmodule

`default_nettype wire

// File: verilog/mod_exponentiator.sv
`timescale 1ns/1ps
`default_nettype none

`include "paillier_consts.svh"

module mod_exponentiator (
    input  logic     clk,
    input  logic     rst_n,
    mod_op_if.engine op
);
    import paillier_pkg::*;

    localparam int CW = $clog2(`PAILLIER_WIDTH);

    typedef enum logic [1:0] {
        EX_IDLE,
        EX_SQR,
        EX_MUL
    } exp_state_t;

    exp_state_t    state;
    word_t         base_q;
    word_t         exp_q;
    word_t         res_q;
    logic [CW-1:0] bit_cnt;
    logic          mul_start;
    logic          done_q;
    logic          accept;
    logic          step_done;
    logic          go_mul;

    mod_op_if mul_bus ();

    mod_multiplier mul_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .op    (mul_bus)
    );

    // Square uses the running result twice, the multiply step brings in the base
    assign mul_bus.start = mul_start;
    assign mul_bus.a     = res_q;
    assign mul_bus.b     = (state == EX_MUL) ? base_q : res_q;

    assign accept    = (state == EX_IDLE) && op.start;
    assign step_done = (state != EX_IDLE) && mul_bus.done;
    assign go_mul    = step_done && (state == EX_SQR) && exp_q[`PAILLIER_WIDTH-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= EX_IDLE;
            bit_cnt   <= '0;
            mul_start <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            mul_start <= 1'b0;
            done_q    <= 1'b0;
            if (accept) begin
                state     <= EX_SQR;
                bit_cnt   <= CW'(`PAILLIER_WIDTH - 1);
                mul_start <= 1'b1;
            end else if (go_mul) begin
                state     <= EX_MUL;
                mul_start <= 1'b1;
            end else if (step_done) begin
                if (bit_cnt == '0) begin
                    state  <= EX_IDLE;
                    done_q <= 1'b1;
                end else begin
                    state     <= EX_SQR;
                    bit_cnt   <= bit_cnt - 1'b1;
                    mul_start <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            base_q <= op.a;
            exp_q  <= op.b;
            res_q  <= word_t'(1);    // A zero exponent leaves this untouched by value
        end else if (step_done) begin
            res_q <= mul_bus.result;
            if (!go_mul) begin
                exp_q <= exp_q << 1;
            end
        end
    end

    assign op.result = res_q;
    assign op.done   = done_q;

endmodule

`default_nettype wire

// File: verilog/task_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "paillier_consts.svh"

module task_sequencer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        task_req,
    input  paillier_pkg::task_cmd_t     task_cmd,
    input  logic                        add_pair_valid,
    input  logic                        scalar_pair_valid,
    input  logic                        fifo_empty,
    input  paillier_pkg::operand_pair_t fifo_head,
    output logic                        fifo_push,
    output logic                        fifo_pop,
    output logic                        pair_select,
    mod_op_if.requester                 mul_bus,
    mod_op_if.requester                 exp_bus,
    output paillier_pkg::word_t         result_data,
    output logic                        result_valid,
    output logic                        task_end
);
    import paillier_pkg::*;

    localparam count_t TASK_LEN = count_t'(`PAILLIER_TASK_LEN);

    seq_state_t state;
    task_cmd_t  cmd_q;
    count_t     push_cnt;
    count_t     res_cnt;
    logic       accept;
    logic       issue;
    logic       eng_done;
    word_t      eng_result;

    // Commands 0 and 1 are not handled here and leave the FSM idle
    assign accept = (state == ST_IDLE) && task_req &&
                    ((task_cmd == CMD_HOMO_ADD) || (task_cmd == CMD_SCALAR_MUL));

    assign pair_select = (cmd_q == CMD_SCALAR_MUL);
    assign fifo_push   = (state != ST_IDLE) && (push_cnt < TASK_LEN) &&
                         (pair_select ? scalar_pair_valid : add_pair_valid);

    // Pop and start share one edge, the engine samples the head before it moves
    assign issue         = (state == ST_ISSUE) && !fifo_empty;
    assign fifo_pop      = issue;
    assign mul_bus.start = issue && !pair_select;
    assign mul_bus.a     = fifo_head.first;
    assign mul_bus.b     = fifo_head.second;
    assign exp_bus.start = issue && pair_select;
    assign exp_bus.a     = fifo_head.first;
    assign exp_bus.b     = fifo_head.second;

    assign eng_done   = pair_select ? exp_bus.done : mul_bus.done;
    assign eng_result = pair_select ? exp_bus.result : mul_bus.result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            cmd_q        <= CMD_HOMO_ADD;
            push_cnt     <= '0;
            res_cnt      <= '0;
            result_data  <= '0;
            result_valid <= 1'b0;
            task_end     <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            task_end     <= 1'b0;
            if (fifo_push) begin
                push_cnt <= push_cnt + 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        cmd_q    <= task_cmd;
                        push_cnt <= '0;
                        res_cnt  <= '0;
                        state    <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    if (issue) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (eng_done) begin
                        result_data  <= eng_result;
                        result_valid <= 1'b1;
                        res_cnt      <= res_cnt + 1'b1;
                        state        <= (res_cnt == TASK_LEN - 1'b1) ? ST_END : ST_ISSUE;
                    end
                end
                ST_END: begin
                    task_end <= 1'b1;  // One cycle after the last result
                    state    <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/paillier_top.sv
`timescale 1ns/1ps
`default_nettype none

module paillier_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [1:0]          task_cmd,
    input  logic                task_req,
    input  paillier_pkg::word_t homo_add_c1,
    input  logic                homo_add_c1_valid,
    input  paillier_pkg::word_t homo_add_c2,
    input  logic                homo_add_c2_valid,
    input  paillier_pkg::word_t scalar_mul_c1,
    input  logic                scalar_mul_c1_valid,
    input  paillier_pkg::word_t scalar_mul_const,
    input  logic                scalar_mul_const_valid,
    output paillier_pkg::word_t result_data,
    output logic                result_valid,
    output logic                task_end
);
    import paillier_pkg::*;

    operand_pair_t fifo_wdata;
    operand_pair_t fifo_rdata;
    logic          fifo_push;
    logic          fifo_pop;
    logic          fifo_empty;
    logic          pair_select;

    mod_op_if seq_mul_bus ();
    mod_op_if seq_exp_bus ();

    // The sequencer chooses which operand stream feeds the FIFO
    always_comb begin
        if (pair_select) begin
            fifo_wdata.first  = scalar_mul_c1;
            fifo_wdata.second = scalar_mul_const;
        end else begin
            fifo_wdata.first  = homo_add_c1;
            fifo_wdata.second = homo_add_c2;
        end
    end

    task_sequencer task_sequencer_inst (
        .clk               (clk),
        .rst_n             (rst_n),
        .task_req          (task_req),
        .task_cmd          (task_cmd_t'(task_cmd)),
        .add_pair_valid    (homo_add_c1_valid && homo_add_c2_valid),
        .scalar_pair_valid (scalar_mul_c1_valid && scalar_mul_const_valid),
        .fifo_empty        (fifo_empty),
        .fifo_head         (fifo_rdata),
        .fifo_push         (fifo_push),
        .fifo_pop          (fifo_pop),
        .pair_select       (pair_select),
        .mul_bus           (seq_mul_bus),
        .exp_bus           (seq_exp_bus),
        .result_data       (result_data),
        .result_valid      (result_valid),
        .task_end          (task_end)
    );

    operand_fifo operand_fifo_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (fifo_push),
        .pop        (fifo_pop),
        .write_data (fifo_wdata),
        .read_data  (fifo_rdata),
        .empty      (fifo_empty),
        .full       ()
    );

    mod_multiplier mod_multiplier_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .op    (seq_mul_bus)
    );

    mod_exponentiator mod_exponentiator_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .op    (seq_exp_bus)
    );

endmodule

`default_nettype wire

// File: bench/paillier_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "paillier_consts.svh"

module paillier_asserts (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     result_valid,
    input logic                     task_end,
    input paillier_pkg::word_t      result_data,
    input paillier_pkg::seq_state_t seq_state
);
    import paillier_pkg::*;

    task_end_single: assert property (@(posedge clk) disable iff (!rst_n)
        task_end |=> !task_end)
        else $error("task_end stayed high for more than one cycle");

    valid_not_idle: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> (seq_state != ST_IDLE))
        else $error("result_valid seen while the sequencer is idle");

    result_reduced: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> (result_data < `PAILLIER_MODULUS))
        else $error("result_data is not reduced below the modulus");

endmodule

bind paillier_top paillier_asserts paillier_asserts_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .result_valid (result_valid),
    .task_end     (task_end),
    .result_data  (result_data),
    .seq_state    (task_sequencer_inst.state)
);

`default_nettype wire

// File: bench/paillier_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "paillier_consts.svh"

module paillier_tb;
    import paillier_pkg::*;

    localparam int     NUM_TASKS   = 3;
    localparam int     BLOCK_WORDS = 1 + 3 * `PAILLIER_TASK_LEN;
    localparam int     TIMEOUT     = 5000;
    localparam time    DRIVE_DELAY = 5;
    localparam count_t TASK_LEN    = count_t'(`PAILLIER_TASK_LEN);

    logic        clk;
    logic        rst_n;
    logic [1:0]  task_cmd;
    logic        task_req;
    word_t       homo_add_c1;
    logic        homo_add_c1_valid;
    word_t       homo_add_c2;
    logic        homo_add_c2_valid;
    word_t       scalar_mul_c1;
    logic        scalar_mul_c1_valid;
    word_t       scalar_mul_const;
    logic        scalar_mul_const_valid;
    word_t       result_data;
    logic        result_valid;
    logic        task_end;

    word_t       golden [NUM_TASKS * BLOCK_WORDS];
    logic [31:0] lcg_state;
    count_t      valid_seen;
    count_t      end_seen;
    int          error_count;
    int          timeout_count;
    bit          aborted;

    paillier_top paillier_top_inst (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .task_cmd               (task_cmd),
        .task_req               (task_req),
        .homo_add_c1            (homo_add_c1),
        .homo_add_c1_valid      (homo_add_c1_valid),
        .homo_add_c2            (homo_add_c2),
        .homo_add_c2_valid      (homo_add_c2_valid),
        .scalar_mul_c1          (scalar_mul_c1),
        .scalar_mul_c1_valid    (scalar_mul_c1_valid),
        .scalar_mul_const       (scalar_mul_const),
        .scalar_mul_const_valid (scalar_mul_const_valid),
        .result_data            (result_data),
        .result_valid           (result_valid),
        .task_end               (task_end)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t golden_word(input int blk, input int offset);
        return golden[blk * BLOCK_WORDS + offset];
    endfunction

    task automatic next_edge();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic compare_word(input string what, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            error_count++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic compare_end(input string what, input count_t got_valid, input count_t got_end,
                               input count_t exp_valid, input count_t exp_end);
        if (got_valid !== exp_valid) begin
            error_count++;
            $display("error at %0t ns: %s gave %0d result pulses, expected %0d",
                     $time, what, got_valid, exp_valid);
        end
        if (got_end !== exp_end) begin
            error_count++;
            $display("error at %0t ns: %s gave %0d task_end pulses, expected %0d",
                     $time, what, got_end, exp_end);
        end
    endtask

    task automatic drive_pair(input logic scalar, input word_t first, input word_t second);
        if (scalar) begin
            scalar_mul_c1          = first;
            scalar_mul_const       = second;
            scalar_mul_c1_valid    = 1'b1;
            scalar_mul_const_valid = 1'b1;
        end else begin
            homo_add_c1       = first;
            homo_add_c2       = second;
            homo_add_c1_valid = 1'b1;
            homo_add_c2_valid = 1'b1;
        end
        next_edge();
        homo_add_c1_valid      = 1'b0;
        homo_add_c2_valid      = 1'b0;
        scalar_mul_c1_valid    = 1'b0;
        scalar_mul_const_valid = 1'b0;
    endtask

    task automatic push_pairs(input int blk);
        logic scalar;
        int   idx;
        int   gap;
        scalar = (golden_word(blk, 0) == word_t'(CMD_SCALAR_MUL));
        for (int i = 0; i <= `PAILLIER_TASK_LEN; i++) begin
            idx = (i < `PAILLIER_TASK_LEN) ? i : `PAILLIER_TASK_LEN - 1;  // Extra pair is dropped
            drive_pair(scalar, golden_word(blk, 1 + 3 * idx), golden_word(blk, 2 + 3 * idx));
            lcg_state = lcg_next(lcg_state);
            gap       = int'(lcg_state[31:30]);
            repeat (gap) next_edge();
        end
    endtask

    task automatic wait_result(output bit found);
        int cycles;
        found  = 1'b0;
        cycles = 0;
        while (!found && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (task_end) end_seen++;
            if (result_valid) begin
                valid_seen++;
                found = 1'b1;
            end
        end
        if (!found) begin
            timeout_count++;
            $display("timeout: no result_valid arrived within %0d cycles", TIMEOUT);
        end
    endtask

    task automatic wait_end(output bit found);
        int cycles;
        found  = 1'b0;
        cycles = 0;
        while (!found && cycles < TIMEOUT) begin
            next_edge();                     // Returns inside the task_end cycle itself
            cycles++;
            if (result_valid) valid_seen++;  // Any pulse here is one too many
            if (task_end) begin
                end_seen++;
                found = 1'b1;
            end
        end
        if (!found) begin
            timeout_count++;
            $display("timeout: task_end did not arrive within %0d cycles", TIMEOUT);
        end
    endtask

    task automatic collect_results(input int blk);
        bit found;
        for (int i = 0; i < `PAILLIER_TASK_LEN; i++) begin
            wait_result(found);
            if (!found) begin
                aborted = 1'b1;
                return;
            end
            compare_word($sformatf("task %0d result %0d", blk, i), result_data,
                         golden_word(blk, 3 + 3 * i));
        end
        wait_end(found);
        if (!found) begin
            aborted = 1'b1;
            return;
        end
        compare_end($sformatf("task %0d", blk), valid_seen, end_seen, TASK_LEN, count_t'(1));
    endtask

    task automatic run_task(input int blk);
        word_t cmd_word;
        cmd_word   = golden_word(blk, 0);
        valid_seen = '0;
        end_seen   = '0;
        task_cmd = cmd_word[1:0];  // Entered just after a rising edge, so the request goes out now
        task_req = 1'b1;
        next_edge();
        task_req = 1'b0;
        fork
            push_pairs(blk);
            collect_results(blk);
        join
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (result_valid) valid_seen++;
            if (task_end) end_seen++;
            compare_word("idle result_data", result_data, '0);
        end
    endtask

    initial begin
        rst_n                  = 1'b0;
        task_cmd               = 2'd0;
        task_req               = 1'b0;
        homo_add_c1            = '0;
        homo_add_c1_valid      = 1'b0;
        homo_add_c2            = '0;
        homo_add_c2_valid      = 1'b0;
        scalar_mul_c1          = '0;
        scalar_mul_c1_valid    = 1'b0;
        scalar_mul_const       = '0;
        scalar_mul_const_valid = 1'b0;
        lcg_state              = 32'ha10b;
        valid_seen             = '0;
        end_seen               = '0;
        error_count            = 0;
        timeout_count          = 0;
        aborted                = 1'b0;

        $readmemh("bench/paillier_golden.txt", golden);
        if ($isunknown(golden[0])) begin
            $display("the golden file bench/paillier_golden.txt could not be read");
            error_count++;
            aborted = 1'b1;
        end

        check_idle(3);           // Reset spans four rising edges
        next_edge();
        rst_n = 1'b1;
        check_idle(3);
        compare_end("idle period", valid_seen, end_seen, '0, '0);
        next_edge();

        for (int blk = 0; blk < NUM_TASKS; blk++) begin
            if (!aborted) run_task(blk);   // The next request is raised in the task_end cycle
        end

        $display("errors: %0d value mismatches, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/paillier_golden.txt
// Each block is one command word (2 = homomorphic add, 3 = scalar multiplication)
// followed by four lines of: first operand, second operand, expected result (hex)
2
3 5 F
0 4D2 0
3E8 7D0 1E8480
755538 2 755537
3
4D2 0 1
162E 1 162E
2 17 AAAC7
0 5 0
2
3039 26F 57E
755538 755538 1
10000 64 640000
1 0 0

// File: compile.f
+incdir+include
verilog/paillier_pkg.sv
verilog/mod_op_if.sv
verilog/operand_fifo.sv
verilog/mod_multiplier.sv
verilog/mod_exponentiator.sv
verilog/task_sequencer.sv
verilog/paillier_top.sv
bench/paillier_asserts.sv
bench/paillier_tb.sv
